/* rtl/his_pkg.sv */
package his_pkg;

    // sensor geometry
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;
    localparam int BIN_NUM = 16;
    localparam int BIN_W = 4;

    // acquisitions per frame
    localparam int ACQ_NUM = 8;
    localparam int ACQ_W = 3;

    // bin counter, saturates at all ones
    localparam int CNT_W = 3;

    // histogram words per bank, index is {pixel, bin}
    localparam int WORDS = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W = 6;

    // wishbone and status sizes
    localparam int WB_AW = 7;
    localparam int WB_DW = 8;
    localparam int FRAME_W = 8;

    // terminal counts
    localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(WORDS - 1);
    localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] LAST_ACQ = ACQ_W'(ACQ_NUM - 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'((1 << CNT_W) - 1);

    // host address map
    localparam logic [WB_AW-1:0] STAT_FRAMES = 7'd0;
    localparam logic [WB_AW-1:0] STAT_BANK = 7'd1;
    localparam logic [WB_AW-1:0] HIST_BASE = 7'd64;

    // one hit word from the tdc front end
    typedef struct packed {
        logic photon;
        logic [BIN_W-1:0] bin;
    } hit_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [WB_DW-1:0] dat_r;
    } wb_rsp_t;

endpackage

/* rtl/his_ctrl.sv */
module his_ctrl (
    input logic clk,
    input logic res,
    input logic hit_valid,
    input logic busy,
    output logic hit_ready,
    output logic acc_go,
    output logic [his_pkg::PIX_W-1:0] acc_pixel,
    output logic bank,
    output logic clr_en,
    output logic [his_pkg::ADDR_W-1:0] clr_addr,
    output logic [his_pkg::FRAME_W-1:0] frames,
    output logic clr_busy
);

    // clear the active bank, collect a frame, wait for the pipeline
    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_COLLECT,
        ST_DRAIN
    } state_t;

    state_t state;
    logic [his_pkg::PIX_W-1:0] pix_cnt;
    logic [his_pkg::ACQ_W-1:0] acq_cnt;
    logic last_pix;
    logic last_acq;
    logic frame_end;

    // input only open while collecting
    assign hit_ready = (state == ST_COLLECT);
    assign acc_go = hit_valid & hit_ready;
    assign acc_pixel = pix_cnt;

    // hits arrive in pixel order, so the pixel is just a counter
    assign last_pix = (pix_cnt == his_pkg::LAST_PIX);
    assign last_acq = (acq_cnt == his_pkg::LAST_ACQ);
    // last pixel of last acquisition accepted now
    assign frame_end = acc_go & last_pix & last_acq;

    assign clr_en = (state == ST_CLEAR);
    // host sees busy from frame end until the new bank is clean
    assign clr_busy = (state != ST_COLLECT);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // reset starts with a clear of bank 1
            state <= ST_CLEAR;
            clr_addr <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            bank <= 1'b0;
            frames <= '0;
        end else begin
            case (state)
                ST_CLEAR: begin
                    // one word per cycle, wraps back to 0 at the end
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == his_pkg::LAST_WORD) begin
                        state <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    if (acc_go) begin
                        pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                        if (last_pix) begin
                            acq_cnt <= last_acq ? '0 : acq_cnt + 1'b1;
                        end
                    end
                    if (frame_end) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // last write has landed, swap the banks
                    if (!busy) begin
                        bank <= ~bank;
                        frames <= frames + 1'b1;
                        state <= ST_CLEAR;
                    end
                end
                default: begin
                    state <= ST_CLEAR;
                end
            endcase
        end
    end

endmodule

/* rtl/his_accum.sv */
module his_accum (
    input logic clk,
    input logic res,
    input logic acc_go,
    input logic [his_pkg::PIX_W-1:0] acc_pixel,
    input his_pkg::hit_t hit,
    input logic [his_pkg::CNT_W-1:0] upd_rdata,
    output logic [his_pkg::ADDR_W-1:0] upd_raddr,
    output logic [his_pkg::ADDR_W-1:0] upd_waddr,
    output logic upd_we,
    output logic [his_pkg::CNT_W-1:0] upd_wdata,
    output logic busy
);

    // stage 0: read issued, waiting for memory data
    logic s0_valid;
    logic [his_pkg::ADDR_W-1:0] s0_idx;

    // stage 1: incremented count, written on the next edge
    logic s1_valid;
    logic [his_pkg::ADDR_W-1:0] s1_idx;
    logic [his_pkg::CNT_W-1:0] s1_data;

    // copy of the write from the edge before
    logic wr_valid;
    logic [his_pkg::ADDR_W-1:0] wr_idx;
    logic [his_pkg::CNT_W-1:0] wr_data;

    logic [his_pkg::CNT_W-1:0] base;
    logic [his_pkg::CNT_W-1:0] incr;

    // word index is {pixel, bin}
    assign upd_raddr = {acc_pixel, hit.bin};

    // forwarding
    always_comb begin
        base = upd_rdata;
        // write still pending in stage 1
        if (s1_valid && (s1_idx == s0_idx)) begin
            base = s1_data;
        // write on the same edge as our read, memory gave the old word
        end else if (wr_valid && (wr_idx == s0_idx)) begin
            base = wr_data;
        end
    end

    // saturating add
    assign incr = (base == his_pkg::CNT_MAX) ? base : base + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            // no photon means a bubble
            s0_valid <= acc_go & hit.photon;
            s1_valid <= s0_valid;
            wr_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s0_idx <= upd_raddr;
        s1_idx <= s0_idx;
        s1_data <= incr;
        wr_idx <= s1_idx;
        wr_data <= s1_data;
    end

    assign upd_we = s1_valid;
    assign upd_waddr = s1_idx;
    assign upd_wdata = s1_data;
    assign busy = s0_valid | s1_valid;

endmodule

/* rtl/his_bank.sv */
module his_bank (
    input logic clk,
    input logic bank,
    input logic [his_pkg::ADDR_W-1:0] upd_raddr,
    input logic [his_pkg::ADDR_W-1:0] upd_waddr,
    input logic upd_we,
    input logic [his_pkg::CNT_W-1:0] upd_wdata,
    input logic clr_en,
    input logic [his_pkg::ADDR_W-1:0] clr_addr,
    input logic [his_pkg::ADDR_W-1:0] ro_addr,
    output logic [his_pkg::CNT_W-1:0] upd_rdata,
    output logic [his_pkg::CNT_W-1:0] ro_data
);

    // ping-pong histogram storage
    logic [his_pkg::CNT_W-1:0] mem0 [his_pkg::WORDS];
    logic [his_pkg::CNT_W-1:0] mem1 [his_pkg::WORDS];

    logic wr_en;
    logic [his_pkg::ADDR_W-1:0] wr_addr;
    logic [his_pkg::CNT_W-1:0] wr_data;

    // clear wins, ctrl keeps clear and update apart anyway
    assign wr_en = clr_en | upd_we;
    assign wr_addr = clr_en ? clr_addr : upd_waddr;
    assign wr_data = clr_en ? '0 : upd_wdata;

    // active bank is ~bank
    always_ff @(posedge clk) begin
        if (wr_en && bank) begin
            mem0[wr_addr] <= wr_data;
        end
        if (wr_en && !bank) begin
            mem1[wr_addr] <= wr_data;
        end
    end

    // update reads from the active bank, old data on a same-edge write
    always_ff @(posedge clk) begin
        upd_rdata <= bank ? mem0[upd_raddr] : mem1[upd_raddr];
    end

    // host reads the finished bank
    always_ff @(posedge clk) begin
        ro_data <= bank ? mem1[ro_addr] : mem0[ro_addr];
    end

endmodule

/* rtl/his_wb_read.sv */
module his_wb_read (
    input logic clk,
    input logic res,
    input his_pkg::wb_req_t wb_req,
    input logic [his_pkg::CNT_W-1:0] ro_data,
    input logic [his_pkg::FRAME_W-1:0] frames,
    input logic bank,
    input logic clr_busy,
    output his_pkg::wb_rsp_t wb_rsp,
    output logic [his_pkg::ADDR_W-1:0] ro_addr
);

    logic start;
    logic pend;
    logic pend_we;
    logic [his_pkg::WB_AW-1:0] pend_adr;
    logic ack_q;
    logic [his_pkg::WB_DW-1:0] dat_q;
    logic [his_pkg::WB_DW-1:0] rd_word;

    // new cycle only when idle, no restart during ack
    assign start = wb_req.cyc & wb_req.stb & ~ack_q & ~pend;

    // memory read launched on the start edge
    assign ro_addr = wb_req.adr[his_pkg::ADDR_W-1:0];

    // response mux, one cycle after start
    always_comb begin
        rd_word = '0;
        if (pend_we) begin
            // writes are ignored
            rd_word = '0;
        end else if (pend_adr >= his_pkg::HIST_BASE) begin
            rd_word = {{(his_pkg::WB_DW - his_pkg::CNT_W){1'b0}}, ro_data};
        end else if (pend_adr == his_pkg::STAT_FRAMES) begin
            rd_word = frames;
        end else if (pend_adr == his_pkg::STAT_BANK) begin
            rd_word = {{(his_pkg::WB_DW - 2){1'b0}}, clr_busy, bank};
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pend <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            pend <= start;
            // single cycle ack
            ack_q <= pend;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pend_we <= wb_req.we;
            pend_adr <= wb_req.adr;
        end
        dat_q <= rd_word;
    end

    assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

endmodule

/* rtl/his_top.sv */
module his_top (
    input logic clk,
    input logic res,
    input logic hit_valid,
    input his_pkg::hit_t hit,
    input his_pkg::wb_req_t wb_req,
    output logic hit_ready,
    output his_pkg::wb_rsp_t wb_rsp
);

    // ctrl to datapath
    logic acc_go;
    logic [his_pkg::PIX_W-1:0] acc_pixel;
    logic bank;
    logic clr_en;
    logic [his_pkg::ADDR_W-1:0] clr_addr;
    logic [his_pkg::FRAME_W-1:0] frames;
    logic clr_busy;
    logic busy;

    // update port
    logic [his_pkg::ADDR_W-1:0] upd_raddr;
    logic [his_pkg::ADDR_W-1:0] upd_waddr;
    logic upd_we;
    logic [his_pkg::CNT_W-1:0] upd_wdata;
    logic [his_pkg::CNT_W-1:0] upd_rdata;

    // readout port
    logic [his_pkg::ADDR_W-1:0] ro_addr;
    logic [his_pkg::CNT_W-1:0] ro_data;

    his_ctrl u_ctrl (
        .clk(clk), .res(res), .hit_valid(hit_valid), .busy(busy),
        .hit_ready(hit_ready), .acc_go(acc_go), .acc_pixel(acc_pixel),
        .bank(bank), .clr_en(clr_en), .clr_addr(clr_addr),
        .frames(frames), .clr_busy(clr_busy)
    );

    his_accum u_accum (
        .clk(clk), .res(res), .acc_go(acc_go), .acc_pixel(acc_pixel),
        .hit(hit), .upd_rdata(upd_rdata), .upd_raddr(upd_raddr),
        .upd_waddr(upd_waddr), .upd_we(upd_we), .upd_wdata(upd_wdata),
        .busy(busy)
    );

    his_bank u_bank (
        .clk(clk), .bank(bank), .upd_raddr(upd_raddr), .upd_waddr(upd_waddr),
        .upd_we(upd_we), .upd_wdata(upd_wdata), .clr_en(clr_en),
        .clr_addr(clr_addr), .ro_addr(ro_addr), .upd_rdata(upd_rdata),
        .ro_data(ro_data)
    );

    // host side
    his_wb_read u_wb_read (
        .clk(clk), .res(res), .wb_req(wb_req), .ro_data(ro_data),
        .frames(frames), .bank(bank), .clr_busy(clr_busy),
        .wb_rsp(wb_rsp), .ro_addr(ro_addr)
    );

endmodule

/* test/his_tb.sv */
module his_tb;

    // rough run length in cycles
    localparam int FRAME_CYCLES = 64 + 32 + 4 + (his_pkg::WORDS + 20) * 4;
    localparam int EST_CYCLES = 8 + 2 * FRAME_CYCLES + 4 * 4;
    // four times the estimate
    localparam int TIMEOUT_CYCLES = 4 * EST_CYCLES;

    // one row per hit and four rows per acquisition
    // pixel is the row index mod 4
    // bit 5 marks a random filler row
    // bit 4 photon flag and bits 3:0 the bin
    localparam logic [5:0] ROWS [64] = '{
        // frame 1 with pixel 0 bin 3 on every acquisition to saturate
        6'h13, 6'h15, 6'h05, 6'h20, 6'h13, 6'h15, 6'h07, 6'h1a,
        6'h13, 6'h12, 6'h0f, 6'h20, 6'h13, 6'h1f, 6'h05, 6'h1a,
        6'h13, 6'h15, 6'h12, 6'h20, 6'h13, 6'h00, 6'h05, 6'h1c,
        6'h13, 6'h15, 6'h0e, 6'h20, 6'h13, 6'h12, 6'h08, 6'h1a,
        // frame 2 uses new bins so leftovers from frame 1 would show
        6'h19, 6'h1e, 6'h20, 6'h13, 6'h19, 6'h0e, 6'h11, 6'h13,
        6'h19, 6'h1e, 6'h20, 6'h13, 6'h09, 6'h10, 6'h11, 6'h13,
        6'h19, 6'h1e, 6'h20, 6'h13, 6'h19, 6'h04, 6'h11, 6'h13,
        6'h19, 6'h1e, 6'h20, 6'h13, 6'h19, 6'h1e, 6'h11, 6'h13
    };

    logic clk;
    logic res;
    logic hit_valid;
    his_pkg::hit_t hit;
    his_pkg::wb_req_t wb_req;
    logic hit_ready;
    his_pkg::wb_rsp_t wb_rsp;

    // expected counts of the frame being collected
    int model [his_pkg::WORDS];
    int errors;
    int checks;
    int cycles;
    int seed;

    his_top DUT (
        .clk(clk), .res(res), .hit_valid(hit_valid), .hit(hit),
        .wb_req(wb_req), .hit_ready(hit_ready), .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, checks: %0d", errors + 1, checks);
            $display("Regression failed");
            $finish;
        end
    end

    // inputs change 1 unit after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    // one wishbone classic cycle with ack expected within 4 cycles
    task automatic wb_access(input logic is_write, input logic [6:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        n = 0;
        rdata = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: is_write, adr: addr, dat_w: wdata};
        tick();
        while (!wb_rsp.ack && n < 4) begin
            tick();
            n++;
        end
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat_r;
        end else begin
            $display("no Wishbone ack for address %0d within 4 cycles at t=%0t", addr, $time);
            errors++;
        end
        wb_req = '0;
        // let ack drop before the next cycle
        tick();
    endtask

    // hold valid until the DUT takes the hit
    task automatic send_hit(input logic photon, input logic [3:0] bin);
        hit_valid = 1'b1;
        hit = '{photon: photon, bin: bin};
        while (!hit_ready) begin
            tick();
        end
        tick();
        hit_valid = 1'b0;
    endtask

    task automatic run_frame(input int f);
        logic [5:0] row;
        logic [31:0] rnd;
        logic photon;
        logic [3:0] bin;
        int pix;
        int idx;
        for (int w = 0; w < his_pkg::WORDS; w++) begin
            model[w] = 0;
        end
        for (int r = 0; r < 32; r++) begin
            row = ROWS[f * 32 + r];
            pix = r % 4;
            if (row[5]) begin
                // filler hit
                rnd = $random(seed);
                photon = rnd[4];
                bin = rnd[3:0];
            end else begin
                photon = row[4];
                bin = row[3:0];
            end
            // counter saturates at 7
            idx = pix * 16 + int'(bin);
            if (photon && model[idx] < 7) begin
                model[idx]++;
            end
            send_hit(photon, bin);
        end
        // frame end closes the input until the new bank is clean
        check("hit_ready", int'(hit_ready), 0);
    endtask

    // busy stays up through drain and clear
    task automatic wait_clear_done();
        logic [7:0] d;
        wb_access(1'b0, his_pkg::STAT_BANK, 8'h00, d);
        while (d[1]) begin
            wb_access(1'b0, his_pkg::STAT_BANK, 8'h00, d);
        end
    endtask

    task automatic check_status(input int done_frames);
        logic [7:0] d;
        wb_access(1'b0, his_pkg::STAT_FRAMES, 8'h00, d);
        check("stat_frames", int'(d), done_frames % 256);
        // bank starts at 0 and toggles once per frame
        wb_access(1'b0, his_pkg::STAT_BANK, 8'h00, d);
        check("stat_bank", int'(d), done_frames % 2);
    endtask

    task automatic check_histogram();
        logic [7:0] d;
        for (int w = 0; w < his_pkg::WORDS; w++) begin
            wb_access(1'b0, 7'(64 + w), 8'h00, d);
            check($sformatf("hist[pix %0d bin %0d]", w / 16, w % 16), int'(d), model[w]);
        end
    endtask

    // host writes are acked and dropped
    task automatic write_then_read(input int done_frames);
        logic [7:0] d;
        wb_access(1'b1, 7'(64 + 3), 8'h05, d);
        wb_access(1'b0, 7'(64 + 3), 8'h00, d);
        check("hist after write", int'(d), model[3]);
        wb_access(1'b1, his_pkg::STAT_FRAMES, 8'haa, d);
        wb_access(1'b0, his_pkg::STAT_FRAMES, 8'h00, d);
        check("stat_frames after write", int'(d), done_frames);
    endtask

    initial begin
        res = 1'b0;
        hit_valid = 1'b0;
        hit = '0;
        wb_req = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed = 4801;
        repeat (8) @(posedge clk);
        #1;
        res = 1'b1;
        // reset clear holds the input off
        check("hit_ready", int'(hit_ready), 0);
        // first hits go in while the reset clear still runs
        for (int f = 0; f < 2; f++) begin
            run_frame(f);
            wait_clear_done();
            check_status(f + 1);
            check_histogram();
        end
        write_then_read(2);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/his_pkg.sv
rtl/his_ctrl.sv
rtl/his_accum.sv
rtl/his_bank.sv
rtl/his_wb_read.sv
rtl/his_top.sv
test/his_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = his_tb
FILELIST = files.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
